// ==== Makefile ====
# Verilator build and run for the rv_control project

VERILATOR  ?= verilator
TOP        ?= tb_control_unit
RTL_TOP    ?= control_unit
FILELIST   ?= rv_control.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/rv_control_config.svh ====
// Cause codes follow the RISC-V mcause numbering for synchronous traps.
// Only the three trap kinds of this control unit are encoded here.

`ifndef RV_CONTROL_CONFIG_SVH
`define RV_CONTROL_CONFIG_SVH

// Width of the cause output
`define CAUSE_WIDTH 4

// Illegal instruction
`define CAUSE_ILLEGAL 4'd2

// Load address misaligned
`define CAUSE_LOAD_MISALIGNED 4'd4

// Store address misaligned
`define CAUSE_STORE_MISALIGNED 4'd6

`endif

// ==== rv_control.f ====
+incdir+include
src/rv_control_pkg.sv
src/field_decoder.sv
src/main_fsm.sv
src/control_unit.sv
verification/tb_control_unit.sv

// ==== src/control_unit.sv ====
// Control unit top. Branch outcome uses funct3[0] only, so beq and bne.
// The combiner adds no cycles; cause is zero outside a trap pulse.

`include "rv_control_config.svh"

module control_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [6:0]                  op,
  input  logic [2:0]                  funct3,
  input  logic                        funct7b5,
  input  logic                        zero,
  input  logic [1:0]                  addr_low,
  input  logic                        mem_ready,
  output logic                        mem_valid,
  output logic                        mem_write,
  output logic                        adr_src,
  output logic                        ir_write,
  output logic                        pc_write,
  output logic                        reg_write,
  output rv_control_pkg::src_a_e      alu_src_a,
  output rv_control_pkg::src_b_e      alu_src_b,
  output rv_control_pkg::alu_ctrl_e   alu_control,
  output rv_control_pkg::result_src_e result_src,
  output rv_control_pkg::imm_src_e    imm_src,
  output rv_control_pkg::load_op_e    load_op,
  output rv_control_pkg::store_op_e   store_op,
  output logic                        exception_event,
  output logic [`CAUSE_WIDTH-1:0]     cause,
  output logic                        incr_inst_retired
);

  rv_control_pkg::opcode_e op_e;
  rv_control_pkg::alu_op_e alu_op;
  rv_control_pkg::trap_e   trap_kind;
  logic legal;
  logic load_misaligned;
  logic store_misaligned;
  logic branch;
  logic pc_update;
  logic taken;

  assign op_e = rv_control_pkg::opcode_e'(op);  // May hold a non-enum value

  main_fsm main_fsm_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .op               (op_e),
    .legal            (legal),
    .load_misaligned  (load_misaligned),
    .store_misaligned (store_misaligned),
    .mem_ready        (mem_ready),
    .mem_valid        (mem_valid),
    .mem_write        (mem_write),
    .adr_src          (adr_src),
    .ir_write         (ir_write),
    .pc_update        (pc_update),
    .branch           (branch),
    .reg_write        (reg_write),
    .alu_src_a        (alu_src_a),
    .alu_src_b        (alu_src_b),
    .alu_op           (alu_op),
    .result_src       (result_src),
    .trap_kind        (trap_kind),
    .incr_inst_retired(incr_inst_retired)
  );

  field_decoder field_decoder_i (
    .op              (op_e),
    .funct3          (funct3),
    .funct7b5        (funct7b5),
    .addr_low        (addr_low),
    .alu_op          (alu_op),
    .alu_control     (alu_control),
    .load_op         (load_op),
    .store_op        (store_op),
    .imm_src         (imm_src),
    .load_misaligned (load_misaligned),
    .store_misaligned(store_misaligned),
    .legal           (legal)
  );

  assign taken    = funct3[0] ? !zero : zero;  // bne : beq
  assign pc_write = (branch && taken) || pc_update;

  assign exception_event = (trap_kind != rv_control_pkg::TRAP_NONE);

  always_comb begin
    case (trap_kind)
      rv_control_pkg::TRAP_ILLEGAL:   cause = `CAUSE_ILLEGAL;
      rv_control_pkg::TRAP_LOAD_MIS:  cause = `CAUSE_LOAD_MISALIGNED;
      rv_control_pkg::TRAP_STORE_MIS: cause = `CAUSE_STORE_MISALIGNED;
      default:                        cause = '0;
    endcase
  end

endmodule

// ==== src/field_decoder.sv ====
// Purely combinational. legal checks only the major opcode, not funct3.
// Misalignment flags are qualified by op and are meant to be sampled in MEM_ADR.

module field_decoder (
  input  rv_control_pkg::opcode_e   op,
  input  logic [2:0]                funct3,
  input  logic                      funct7b5,
  input  logic [1:0]                addr_low,
  input  rv_control_pkg::alu_op_e   alu_op,
  output rv_control_pkg::alu_ctrl_e alu_control,
  output rv_control_pkg::load_op_e  load_op,
  output rv_control_pkg::store_op_e store_op,
  output rv_control_pkg::imm_src_e  imm_src,
  output logic                      load_misaligned,
  output logic                      store_misaligned,
  output logic                      legal
);

  logic misaligned;

  always_comb begin
    unique case (alu_op)
      rv_control_pkg::ALUOP_SUB: alu_control = rv_control_pkg::ALU_SUB;  // Branch compare
      rv_control_pkg::ALUOP_FUNCT: begin
        unique case (funct3)
          3'b000: alu_control = (op == rv_control_pkg::OPC_OP && funct7b5) ?
                                rv_control_pkg::ALU_SUB : rv_control_pkg::ALU_ADD;  // No subi
          3'b001: alu_control = rv_control_pkg::ALU_SLL;
          3'b010: alu_control = rv_control_pkg::ALU_SLT;
          3'b011: alu_control = rv_control_pkg::ALU_SLTU;
          3'b100: alu_control = rv_control_pkg::ALU_XOR;
          3'b101: alu_control = funct7b5 ? rv_control_pkg::ALU_SRA : rv_control_pkg::ALU_SRL;
          3'b110: alu_control = rv_control_pkg::ALU_OR;
          default: alu_control = rv_control_pkg::ALU_AND;
        endcase
      end
      default: alu_control = rv_control_pkg::ALU_ADD;  // Address and PC arithmetic
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: load_op = rv_control_pkg::LD_LB;
      3'b001: load_op = rv_control_pkg::LD_LH;
      3'b100: load_op = rv_control_pkg::LD_LBU;
      3'b101: load_op = rv_control_pkg::LD_LHU;
      default: load_op = rv_control_pkg::LD_LW;
    endcase
    case (funct3[1:0])
      2'b00: store_op = rv_control_pkg::ST_SB;
      2'b01: store_op = rv_control_pkg::ST_SH;
      default: store_op = rv_control_pkg::ST_SW;
    endcase
  end

  always_comb begin
    legal   = 1'b1;
    imm_src = rv_control_pkg::IMM_I;
    case (op)
      rv_control_pkg::OPC_OP:     imm_src = rv_control_pkg::IMM_I;  // Unused by R-type
      rv_control_pkg::OPC_OP_IMM,
      rv_control_pkg::OPC_LOAD:   imm_src = rv_control_pkg::IMM_I;
      rv_control_pkg::OPC_STORE:  imm_src = rv_control_pkg::IMM_S;
      rv_control_pkg::OPC_BRANCH: imm_src = rv_control_pkg::IMM_B;
      rv_control_pkg::OPC_JAL:    imm_src = rv_control_pkg::IMM_J;
      rv_control_pkg::OPC_LUI:    imm_src = rv_control_pkg::IMM_U;
      default: legal = 1'b0;
    endcase
  end

  // Halfword at odd byte, word off a 4-byte boundary
  assign misaligned = (funct3[1:0] == 2'b01 && addr_low[0]) ||
                      (funct3[1:0] == 2'b10 && addr_low != 2'b00);

  assign load_misaligned  = (op == rv_control_pkg::OPC_LOAD) && misaligned;
  assign store_misaligned = (op == rv_control_pkg::OPC_STORE) && misaligned;

  // Unused ALU class code would silently fall back to ADD
  a_alu_op_known: assert final (alu_op inside {
      rv_control_pkg::ALUOP_ADD, rv_control_pkg::ALUOP_SUB, rv_control_pkg::ALUOP_FUNCT})
    else $error("alu_op %b has no encoding", alu_op);

endmodule

// ==== src/main_fsm.sv ====
// Multicycle sequencer. Outputs decode from the state, plus mem_ready in the wait states.
// op and the decoder flags must be stable from DECODE until the next FETCH.

module main_fsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  rv_control_pkg::opcode_e     op,
  input  logic                        legal,
  input  logic                        load_misaligned,
  input  logic                        store_misaligned,
  input  logic                        mem_ready,
  output logic                        mem_valid,
  output logic                        mem_write,
  output logic                        adr_src,
  output logic                        ir_write,
  output logic                        pc_update,
  output logic                        branch,
  output logic                        reg_write,
  output rv_control_pkg::src_a_e      alu_src_a,
  output rv_control_pkg::src_b_e      alu_src_b,
  output rv_control_pkg::alu_op_e     alu_op,
  output rv_control_pkg::result_src_e result_src,
  output rv_control_pkg::trap_e       trap_kind,
  output logic                        incr_inst_retired
);

  rv_control_pkg::fsm_state_e state_q, state_d;
  rv_control_pkg::trap_e      trap_q, trap_d;  // Kind reported while in TRAP

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= rv_control_pkg::S_FETCH;
      trap_q  <= rv_control_pkg::TRAP_NONE;
    end else begin
      state_q <= state_d;
      trap_q  <= trap_d;
    end
  end

  always_comb begin
    state_d = state_q;
    trap_d  = rv_control_pkg::TRAP_NONE;
    case (state_q)
      rv_control_pkg::S_FETCH:
        if (mem_ready) state_d = rv_control_pkg::S_DECODE;
      rv_control_pkg::S_DECODE: begin
        if (!legal) begin
          state_d = rv_control_pkg::S_TRAP;
          trap_d  = rv_control_pkg::TRAP_ILLEGAL;
        end else begin
          case (op)
            rv_control_pkg::OPC_LOAD,
            rv_control_pkg::OPC_STORE:  state_d = rv_control_pkg::S_MEM_ADR;
            rv_control_pkg::OPC_OP:     state_d = rv_control_pkg::S_EXECUTE_R;
            rv_control_pkg::OPC_OP_IMM: state_d = rv_control_pkg::S_EXECUTE_I;
            rv_control_pkg::OPC_BRANCH: state_d = rv_control_pkg::S_BRANCH;
            rv_control_pkg::OPC_JAL:    state_d = rv_control_pkg::S_JAL;
            default:                    state_d = rv_control_pkg::S_LUI;
          endcase
        end
      end
      rv_control_pkg::S_MEM_ADR: begin
        if (op == rv_control_pkg::OPC_LOAD) begin
          state_d = load_misaligned ? rv_control_pkg::S_TRAP : rv_control_pkg::S_MEM_READ;
          if (load_misaligned) trap_d = rv_control_pkg::TRAP_LOAD_MIS;
        end else begin
          state_d = store_misaligned ? rv_control_pkg::S_TRAP : rv_control_pkg::S_MEM_WRITE;
          if (store_misaligned) trap_d = rv_control_pkg::TRAP_STORE_MIS;
        end
      end
      rv_control_pkg::S_MEM_READ:
        if (mem_ready) state_d = rv_control_pkg::S_MEM_WB;
      rv_control_pkg::S_MEM_WRITE:
        if (mem_ready) state_d = rv_control_pkg::S_FETCH;
      rv_control_pkg::S_EXECUTE_R,
      rv_control_pkg::S_EXECUTE_I,
      rv_control_pkg::S_JAL:       state_d = rv_control_pkg::S_ALU_WB;
      default:                     state_d = rv_control_pkg::S_FETCH;  // Single-cycle tails
    endcase
  end

  always_comb begin
    mem_valid         = 1'b0;
    mem_write         = 1'b0;
    adr_src           = 1'b0;
    ir_write          = 1'b0;
    pc_update         = 1'b0;
    branch            = 1'b0;
    reg_write         = 1'b0;
    incr_inst_retired = 1'b0;
    alu_src_a         = rv_control_pkg::SRCA_RS1;
    alu_src_b         = rv_control_pkg::SRCB_IMM;
    alu_op            = rv_control_pkg::ALUOP_ADD;
    result_src        = rv_control_pkg::RES_ALU_OUT;
    trap_kind         = rv_control_pkg::TRAP_NONE;
    case (state_q)
      rv_control_pkg::S_FETCH: begin
        mem_valid  = 1'b1;
        ir_write   = mem_ready;
        pc_update  = mem_ready;  // PC <= PC + 4
        alu_src_a  = rv_control_pkg::SRCA_PC;
        alu_src_b  = rv_control_pkg::SRCB_FOUR;
        result_src = rv_control_pkg::RES_ALU_RESULT;
      end
      rv_control_pkg::S_DECODE:
        alu_src_a = rv_control_pkg::SRCA_OLD_PC;  // Branch and jump target
      rv_control_pkg::S_MEM_READ: begin
        mem_valid = 1'b1;
        adr_src   = 1'b1;
      end
      rv_control_pkg::S_MEM_WB: begin
        result_src        = rv_control_pkg::RES_DATA;
        reg_write         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      rv_control_pkg::S_MEM_WRITE: begin
        mem_valid         = 1'b1;
        mem_write         = 1'b1;
        adr_src           = 1'b1;
        incr_inst_retired = mem_ready;
      end
      rv_control_pkg::S_EXECUTE_R: begin
        alu_src_b = rv_control_pkg::SRCB_RS2;
        alu_op    = rv_control_pkg::ALUOP_FUNCT;
      end
      rv_control_pkg::S_EXECUTE_I: alu_op = rv_control_pkg::ALUOP_FUNCT;
      rv_control_pkg::S_ALU_WB: begin
        reg_write         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      rv_control_pkg::S_BRANCH: begin
        alu_src_b         = rv_control_pkg::SRCB_RS2;
        alu_op            = rv_control_pkg::ALUOP_SUB;
        branch            = 1'b1;
        incr_inst_retired = 1'b1;
      end
      rv_control_pkg::S_JAL: begin
        alu_src_a = rv_control_pkg::SRCA_OLD_PC;  // Link value, target sits in ALUOut
        alu_src_b = rv_control_pkg::SRCB_FOUR;
        pc_update = 1'b1;
      end
      rv_control_pkg::S_LUI: begin
        result_src        = rv_control_pkg::RES_IMM;
        reg_write         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      rv_control_pkg::S_TRAP: trap_kind = trap_q;
      default: ;
    endcase
  end

  // Store request stays up, still a write, until the memory takes it
  a_store_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_write && !mem_ready |=> mem_write && mem_valid);

  a_trap_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    trap_kind != rv_control_pkg::TRAP_NONE |=> trap_kind == rv_control_pkg::TRAP_NONE);

endmodule

// ==== src/rv_control_pkg.sv ====
// Types shared by the control unit parts.
// Enum labels carry a prefix, since all of them share the package scope.

package rv_control_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    S_FETCH, S_DECODE, S_MEM_ADR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE, S_EXECUTE_R,
    S_EXECUTE_I, S_ALU_WB, S_BRANCH, S_JAL, S_LUI, S_TRAP
  } fsm_state_e;

  typedef enum logic [1:0] {ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT} alu_op_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_ctrl_e;

  typedef enum logic [2:0] {LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU} load_op_e;

  typedef enum logic [1:0] {ST_SB, ST_SH, ST_SW} store_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_src_e;

  typedef enum logic [1:0] {SRCA_PC, SRCA_OLD_PC, SRCA_RS1} src_a_e;

  typedef enum logic [1:0] {SRCB_RS2, SRCB_IMM, SRCB_FOUR} src_b_e;

  typedef enum logic [1:0] {RES_ALU_OUT, RES_DATA, RES_ALU_RESULT, RES_IMM} result_src_e;

  typedef enum logic [1:0] {TRAP_NONE, TRAP_ILLEGAL, TRAP_LOAD_MIS, TRAP_STORE_MIS} trap_e;

endpackage

// ==== verification/tb_control_unit.sv ====
// Self-checking testbench for control_unit, acting as datapath and memory.
// Fields and memory stalls (0 to 3 per access) come from a 16-bit LFSR.

`include "rv_control_config.svh"

module tb_control_unit;

  localparam int N_INSTR     = 300;
  localparam int CYCLE_LIMIT = N_INSTR * 16;  // Worst case is 11 cycles per instruction

  typedef struct packed {
    logic [3:0] cause;
    logic       taken;
    logic [2:0] load_op;
    logic [1:0] store_op;
    logic [3:0] alu_ctrl;
    logic       check_alu;
    logic [2:0] imm_src;
    logic [1:0] wb_src;      // Result source when reg_write is high
    logic [1:0] exec_src_b;  // ALU B source in the execute cycle
    logic [2:0] cycles;      // Without memory stalls
    logic       mem_access;  // One data transfer expected
    logic       is_store;
    logic       reg_write;
    logic       retire;
    logic       pc_write;
  } expect_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic [6:0] op;
  logic [2:0] funct3;
  logic       funct7b5;
  logic       zero;
  logic [1:0] addr_low;
  logic       mem_ready;
  logic       mem_valid;
  logic       mem_write;
  logic       adr_src;
  logic       ir_write;
  logic       pc_write;
  logic       reg_write;
  logic       exception_event;
  logic       incr_inst_retired;
  logic [`CAUSE_WIDTH-1:0]     cause;
  rv_control_pkg::src_a_e      alu_src_a;
  rv_control_pkg::src_b_e      alu_src_b;
  rv_control_pkg::alu_ctrl_e   alu_control;
  rv_control_pkg::result_src_e result_src;
  rv_control_pkg::imm_src_e    imm_src;
  rv_control_pkg::load_op_e    load_op;
  rv_control_pkg::store_op_e   store_op;

  logic [15:0] lfsr_state = 16'd17334;
  logic [1:0]  stall_left = 2'd0;
  expect_t     exp_q;
  logic        in_instr = 1'b0;
  int          n_cycles;
  int          n_regw;
  int          n_ret;
  int          n_exc;
  int          n_pcw;
  int          n_xfer;
  int          instr_done = 0;
  int          errors = 0;
  int          cycle_count = 0;

  control_unit UUT (.*);

  always #50 clk = ~clk;

  // Taps x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] bits);
    bits = 8'd0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[6:0], lfsr_state[0]};
    end
  endtask

  // RV32I major opcodes handled by the control unit
  function automatic logic known_opcode(input logic [6:0] o);
    return o inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                     7'b1101111, 7'b0110111};
  endfunction

  function automatic expect_t expected_result(input logic [6:0] o, input logic [2:0] f3,
                                              input logic f7b5, input logic z,
                                              input logic [1:0] a);
    expect_t e;
    logic    mis;
    int      size;
    e = '0;
    size = 1 << f3[1:0];  // Access bytes
    mis = (int'(a) % size) != 0;
    e.taken = (f3 == 3'b000) ? z : !z;  // beq needs zero, bne needs not zero
    case (f3)
      3'b000: e.load_op = rv_control_pkg::LD_LB;
      3'b001: e.load_op = rv_control_pkg::LD_LH;
      3'b010: e.load_op = rv_control_pkg::LD_LW;
      3'b100: e.load_op = rv_control_pkg::LD_LBU;
      default: e.load_op = rv_control_pkg::LD_LHU;
    endcase
    e.store_op = (f3[1:0] == 2'b00) ? rv_control_pkg::ST_SB :
                 (f3[1:0] == 2'b01) ? rv_control_pkg::ST_SH : rv_control_pkg::ST_SW;
    case (f3)
      3'b000: e.alu_ctrl = (o == 7'b0110011 && f7b5) ? rv_control_pkg::ALU_SUB :
                                                       rv_control_pkg::ALU_ADD;
      3'b001: e.alu_ctrl = rv_control_pkg::ALU_SLL;
      3'b010: e.alu_ctrl = rv_control_pkg::ALU_SLT;
      3'b011: e.alu_ctrl = rv_control_pkg::ALU_SLTU;
      3'b100: e.alu_ctrl = rv_control_pkg::ALU_XOR;
      3'b101: e.alu_ctrl = f7b5 ? rv_control_pkg::ALU_SRA : rv_control_pkg::ALU_SRL;
      3'b110: e.alu_ctrl = rv_control_pkg::ALU_OR;
      default: e.alu_ctrl = rv_control_pkg::ALU_AND;
    endcase
    if (!known_opcode(o)) begin
      e.cause  = `CAUSE_ILLEGAL;
      e.cycles = 3'd2;
    end else if (o == 7'b0000011 || o == 7'b0100011) begin
      e.is_store = o[5];  // Set only for STORE
      e.imm_src  = e.is_store ? rv_control_pkg::IMM_S : rv_control_pkg::IMM_I;
      e.wb_src   = rv_control_pkg::RES_DATA;
      if (mis) begin
        e.cause  = e.is_store ? `CAUSE_STORE_MISALIGNED : `CAUSE_LOAD_MISALIGNED;
        e.cycles = 3'd3;
      end else begin
        e.mem_access = 1'b1;
        e.retire     = 1'b1;
        e.reg_write  = !e.is_store;
        e.cycles     = e.is_store ? 3'd3 : 3'd4;
      end
    end else begin
      e.retire = 1'b1;
      case (o)
        7'b0110011, 7'b0010011: begin
          e.check_alu  = 1'b1;
          e.reg_write  = 1'b1;
          e.cycles     = 3'd3;
          e.imm_src    = rv_control_pkg::IMM_I;
          e.wb_src     = rv_control_pkg::RES_ALU_OUT;
          e.exec_src_b = (o == 7'b0110011) ? rv_control_pkg::SRCB_RS2 :
                                             rv_control_pkg::SRCB_IMM;
        end
        7'b1100011: begin
          e.pc_write = e.taken;
          e.cycles   = 3'd2;
          e.imm_src  = rv_control_pkg::IMM_B;
        end
        7'b1101111: begin
          e.pc_write  = 1'b1;
          e.reg_write = 1'b1;
          e.cycles    = 3'd3;
          e.imm_src   = rv_control_pkg::IMM_J;
          e.wb_src    = rv_control_pkg::RES_ALU_OUT;
        end
        default: begin  // lui
          e.reg_write = 1'b1;
          e.cycles    = 3'd2;
          e.imm_src   = rv_control_pkg::IMM_U;
          e.wb_src    = rv_control_pkg::RES_IMM;
        end
      endcase
    end
    return e;
  endfunction

  task automatic pick_instruction();
    logic [7:0] b;
    logic [6:0] new_op;
    logic [2:0] new_f3;
    draw_bits(3, b);
    case (b[2:0])
      3'd0: new_op = rv_control_pkg::OPC_OP;
      3'd1: new_op = rv_control_pkg::OPC_OP_IMM;
      3'd2: new_op = rv_control_pkg::OPC_LOAD;
      3'd3: new_op = rv_control_pkg::OPC_STORE;
      3'd4: new_op = rv_control_pkg::OPC_BRANCH;
      3'd5: new_op = rv_control_pkg::OPC_JAL;
      3'd6: new_op = rv_control_pkg::OPC_LUI;
      default: begin
        draw_bits(7, b);
        new_op = b[6:0];
        if (known_opcode(new_op)) new_op = new_op ^ 7'b0001000;  // Lands outside the set
      end
    endcase
    draw_bits(3, b);
    new_f3 = b[2:0];
    if (new_op == rv_control_pkg::OPC_LOAD && new_f3 inside {3'b011, 3'b110, 3'b111})
      new_f3 = 3'b010;
    if (new_op == rv_control_pkg::OPC_STORE)
      new_f3 = (new_f3[1:0] == 2'b11) ? 3'b010 : {1'b0, new_f3[1:0]};
    if (new_op == rv_control_pkg::OPC_BRANCH) new_f3 = {2'b00, new_f3[0]};  // beq or bne
    op     <= new_op;
    funct3 <= new_f3;
    draw_bits(1, b);
    funct7b5 <= b[0];
    draw_bits(1, b);
    zero <= b[0];
    draw_bits(2, b);
    addr_low <= b[1:0];
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("Summary: %0d instructions checked, %0d errors", instr_done, errors);
  endtask

  // Memory back-pressure and new fields, decided from the cycle just ended
  always @(posedge clk) begin
    logic [7:0] b;
    if (rst_n) begin
      if (ir_write) pick_instruction();
      if (mem_valid && mem_ready) begin
        draw_bits(2, b);
        stall_left = b[1:0];
      end else if (mem_valid && stall_left != 2'd0) begin
        stall_left = stall_left - 2'd1;
      end
      mem_ready <= (stall_left == 2'd0);
    end
  end

  // Follows each instruction from ir_write to the next FETCH
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_instr && !(mem_valid && !adr_src)) begin
        if (n_cycles == 0) exp_q = expected_result(op, funct3, funct7b5, zero, addr_low);
        if (!(mem_valid && adr_src && !mem_ready)) n_cycles++;
        if (mem_valid && adr_src) begin
          if (!exp_q.mem_access || mem_write != exp_q.is_store)
            report_error($sformatf("unexpected data access for op %b", op));
          else if (exp_q.is_store && store_op != exp_q.store_op)
            report_error($sformatf("store_op %0d, expected %0d", store_op, exp_q.store_op));
          else if (!exp_q.is_store && load_op != exp_q.load_op)
            report_error($sformatf("load_op %0d, expected %0d", load_op, exp_q.load_op));
          if (mem_ready) n_xfer++;
        end
        if (mem_write && !(mem_valid && adr_src))
          report_error("mem_write without a data request");
        if (reg_write && !incr_inst_retired)
          report_error("reg_write without incr_inst_retired");
        if (exception_event && cause != exp_q.cause)
          report_error($sformatf("cause %0d, expected %0d", cause, exp_q.cause));
        if (exp_q.check_alu && n_cycles == 2 && alu_control != exp_q.alu_ctrl)
          report_error($sformatf("alu_control %0d, expected %0d for op %b funct3 %b",
                                 alu_control, exp_q.alu_ctrl, op, funct3));
        if (exp_q.check_alu && n_cycles == 2 &&
            (alu_src_a != rv_control_pkg::SRCA_RS1 || alu_src_b != exp_q.exec_src_b))
          report_error($sformatf("ALU sources %0d and %0d in execute for op %b",
                                 alu_src_a, alu_src_b, op));
        if (n_cycles == 1 && exp_q.cause != `CAUSE_ILLEGAL && imm_src != exp_q.imm_src)
          report_error($sformatf("imm_src %0d, expected %0d for op %b",
                                 imm_src, exp_q.imm_src, op));
        if (reg_write && result_src != exp_q.wb_src)
          report_error($sformatf("result_src %0d, expected %0d for op %b",
                                 result_src, exp_q.wb_src, op));
        if (reg_write) n_regw++;
        if (incr_inst_retired) n_ret++;
        if (exception_event) n_exc++;
        if (pc_write) n_pcw++;
      end else begin
        if (in_instr) begin
          if (n_cycles != int'(exp_q.cycles))
            report_error($sformatf("op %b took %0d cycles, expected %0d",
                                   op, n_cycles, exp_q.cycles));
          if (n_regw != int'(exp_q.reg_write))
            report_error($sformatf("%0d reg_write pulses for op %b", n_regw, op));
          if (n_ret != int'(exp_q.retire))
            report_error($sformatf("%0d retire pulses for op %b", n_ret, op));
          if (n_exc != int'(exp_q.cause != 4'd0))
            report_error($sformatf("%0d exception pulses for op %b", n_exc, op));
          if (n_pcw != int'(exp_q.pc_write))
            report_error($sformatf("%0d pc_write cycles for op %b zero %b", n_pcw, op, zero));
          if (n_xfer != int'(exp_q.mem_access))
            report_error($sformatf("%0d data transfers for op %b", n_xfer, op));
          instr_done++;
        end
        if (!mem_valid || adr_src)
          report_error("fetch request missing");
        if (mem_write || reg_write || exception_event || incr_inst_retired)
          report_error("write strobe high during fetch");
        if (ir_write != mem_ready || pc_write != mem_ready)
          report_error("ir_write or pc_write does not follow mem_ready in fetch");
        if (alu_src_a != rv_control_pkg::SRCA_PC || alu_src_b != rv_control_pkg::SRCB_FOUR ||
            result_src != rv_control_pkg::RES_ALU_RESULT)
          report_error("fetch does not select PC + 4 as the result");
        in_instr = ir_write;
        n_cycles = 0;
        n_regw   = 0;
        n_ret    = 0;
        n_exc    = 0;
        n_pcw    = 0;
        n_xfer   = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: only %0d of %0d instructions completed after %0d cycles",
               instr_done, N_INSTR, cycle_count);
      print_summary();
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    rst_n     <= 1'b0;
    op        <= rv_control_pkg::OPC_LUI;
    funct3    <= 3'b000;
    funct7b5  <= 1'b0;
    zero      <= 1'b0;
    addr_low  <= 2'b00;
    mem_ready <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait (instr_done == N_INSTR);
    @(posedge clk);
    print_summary();
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
